/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import id_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  word_t     pc_i,
    input  word_t     instr_i,
    input  logic      ex_wb_valid_i,
    input  regaddr_t  ex_wb_addr_i,
    input  word_t     ex_wb_data_i,
    input  logic      ex_wb_ready_i,
    input  logic      ma_wb_valid_i,
    input  regaddr_t  ma_wb_addr_i,
    input  word_t     ma_wb_data_i,
    input  logic      ma_wb_ready_i,
    input  logic      wb_valid_i,
    input  regaddr_t  wb_addr_i,
    input  word_t     wb_data_i,
    output logic      jmp_valid_o,
    output word_t     jmp_addr_o,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output word_t     pc_o,
    output word_t     instr_o,
    output word_t     alu_op1_o,
    output word_t     alu_op2_o,
    output alu_mode_t alu_mode_o,
    output ma_mode_t  ma_mode_o,
    output ma_size_t  ma_size_o,
    output word_t     ma_data_o,
    output wb_src_t   wb_src_o,
    output regaddr_t  wb_addr_o,
    output logic      wb_en_o,
    output word_t     link_o
);

regaddr_t           rs_idx [NUM_SRC];
logic [NUM_SRC-1:0] rs_used;
word_t              rf_data [NUM_SRC];
word_t              op_value [NUM_SRC];
logic [NUM_SRC-1:0] op_hazard;
regaddr_t           rd;
logic [2:0]         funct3;
word_t              imm_i;
word_t              imm_s;
word_t              imm_b;
word_t              imm_u;
word_t              imm_j;
alu_op1_t           op1_sel;
alu_op2_t           op2_sel;
alu_mode_t          dec_alu_mode;
pc_mode_t           dec_pc_mode;
ma_mode_t           dec_ma_mode;
ma_size_t           dec_ma_size;
wb_src_t            dec_wb_src;
logic               dec_wb_en;

instr_decode u_decode (
    .instr_i       (instr_i),
    .rs_idx_o      (rs_idx),
    .rs_used_o     (rs_used),
    .rd_o          (rd),
    .funct3_o      (funct3),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_b_o       (imm_b),
    .imm_u_o       (imm_u),
    .imm_j_o       (imm_j),
    .alu_op1_sel_o (op1_sel),
    .alu_op2_sel_o (op2_sel),
    .alu_mode_o    (dec_alu_mode),
    .pc_mode_o     (dec_pc_mode),
    .ma_mode_o     (dec_ma_mode),
    .ma_size_o     (dec_ma_size),
    .wb_src_o      (dec_wb_src),
    .wb_en_o       (dec_wb_en)
);

// write-back owns the write port
reg_file u_rf (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_addr_i (rs_idx),
    .rd_data_o (rf_data),
    .wr_en_i   (wb_valid_i),
    .wr_addr_i (wb_addr_i),
    .wr_data_i (wb_data_i)
);

for (genvar k = 0; k < NUM_SRC; k++) begin : g_src
    operand_bypass u_bypass (
        .rs_idx_i   (rs_idx[k]),
        .rs_used_i  (rs_used[k]),
        .rf_data_i  (rf_data[k]),
        .ex_valid_i (ex_wb_valid_i),
        .ex_addr_i  (ex_wb_addr_i),
        .ex_data_i  (ex_wb_data_i),
        .ex_ready_i (ex_wb_ready_i),
        .ma_valid_i (ma_wb_valid_i),
        .ma_addr_i  (ma_wb_addr_i),
        .ma_data_i  (ma_wb_data_i),
        .ma_ready_i (ma_wb_ready_i),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .value_o    (op_value[k]),
        .hazard_o   (op_hazard[k])
    );
end

// handshake and output group match the top-level port names
issue_stage u_issue (
    .rd_i          (rd),
    .funct3_i      (funct3),
    .imm_i_i       (imm_i),
    .imm_s_i       (imm_s),
    .imm_b_i       (imm_b),
    .imm_u_i       (imm_u),
    .imm_j_i       (imm_j),
    .alu_op1_sel_i (op1_sel),
    .alu_op2_sel_i (op2_sel),
    .alu_mode_i    (dec_alu_mode),
    .pc_mode_i     (dec_pc_mode),
    .ma_mode_i     (dec_ma_mode),
    .ma_size_i     (dec_ma_size),
    .wb_src_i      (dec_wb_src),
    .wb_en_i       (dec_wb_en),
    .op_value_i    (op_value),
    .op_hazard_i   (op_hazard),
    .*
);

endmodule

/* logic/id_pkg.sv */
package id_pkg;

localparam int unsigned XLEN        = 32;
localparam int unsigned NUM_REGS    = 32;
localparam int unsigned NUM_SRC     = 2;    // rs1 and rs2
localparam int unsigned INSTR_BYTES = 4;

typedef logic [XLEN-1:0] word_t;
typedef logic [4:0]      regaddr_t;
typedef logic [6:0]      opcode_t;

// major opcodes
localparam opcode_t OPC_LUI    = 7'b0110111;
localparam opcode_t OPC_AUIPC  = 7'b0010111;
localparam opcode_t OPC_JAL    = 7'b1101111;
localparam opcode_t OPC_JALR   = 7'b1100111;
localparam opcode_t OPC_BRANCH = 7'b1100011;
localparam opcode_t OPC_LOAD   = 7'b0000011;
localparam opcode_t OPC_STORE  = 7'b0100011;
localparam opcode_t OPC_OP_IMM = 7'b0010011;
localparam opcode_t OPC_OP     = 7'b0110011;

// branch conditions
localparam logic [2:0] F3_BEQ  = 3'b000;
localparam logic [2:0] F3_BNE  = 3'b001;
localparam logic [2:0] F3_BLT  = 3'b100;
localparam logic [2:0] F3_BGE  = 3'b101;
localparam logic [2:0] F3_BLTU = 3'b110;
localparam logic [2:0] F3_BGEU = 3'b111;

typedef struct packed {
    logic [6:0] funct7;
    regaddr_t   rs2;
    regaddr_t   rs1;
    logic [2:0] funct3;
    regaddr_t   rd;
    opcode_t    opcode;
} instr_r_t;

typedef struct packed {
    logic [11:0] imm12;
    regaddr_t    rs1;
    logic [2:0]  funct3;
    regaddr_t    rd;
    opcode_t     opcode;
} instr_i_t;

// same instruction word, register view and immediate view
typedef union packed {
    instr_r_t r;
    instr_i_t i;
} instr_u;

typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
} alu_mode_t;

typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_PC} alu_op1_t;
typedef enum logic [2:0] {
    OP2_ZERO, OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_IMM_U, OP2_FOUR
} alu_op2_t;
typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_t;

// bit 2 flags an unsigned load, same layout as the load funct3
typedef enum logic [2:0] {
    MA_SIZE_B  = 3'b000,
    MA_SIZE_H  = 3'b001,
    MA_SIZE_W  = 3'b010,
    MA_SIZE_BU = 3'b100,
    MA_SIZE_HU = 3'b101
} ma_size_t;

typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_LINK} wb_src_t;

endpackage

/* logic/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import id_pkg::*;
(
    input  word_t              instr_i,
    output regaddr_t           rs_idx_o [NUM_SRC],
    output logic [NUM_SRC-1:0] rs_used_o,
    output regaddr_t           rd_o,
    output logic [2:0]         funct3_o,
    output word_t              imm_i_o,
    output word_t              imm_s_o,
    output word_t              imm_b_o,
    output word_t              imm_u_o,
    output word_t              imm_j_o,
    output alu_op1_t           alu_op1_sel_o,
    output alu_op2_t           alu_op2_sel_o,
    output alu_mode_t          alu_mode_o,
    output pc_mode_t           pc_mode_o,
    output ma_mode_t           ma_mode_o,
    output ma_size_t           ma_size_o,
    output wb_src_t            wb_src_o,
    output logic               wb_en_o
);

instr_u    ins;
logic      wr_rd;       // format writes rd
alu_mode_t arith_mode;  // funct3/funct7 mapping

assign ins         = instr_i;
assign rs_idx_o[0] = ins.r.rs1;
assign rs_idx_o[1] = ins.r.rs2;
assign rd_o        = ins.r.rd;
assign funct3_o    = ins.r.funct3;

// sign-extended immediate formats
assign imm_i_o = {{20{ins.i.imm12[11]}}, ins.i.imm12};
assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
assign imm_b_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
assign imm_u_o = {instr_i[31:12], 12'b0};
assign imm_j_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

always_comb begin
    case (ins.r.funct3)
        3'b000:  arith_mode = (ins.r.opcode == OPC_OP && ins.r.funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b001:  arith_mode = ALU_SLL;
        3'b010:  arith_mode = ALU_SLT;
        3'b011:  arith_mode = ALU_SLTU;
        3'b100:  arith_mode = ALU_XOR;
        3'b101:  arith_mode = ins.r.funct7[5] ? ALU_SRA : ALU_SRL;  // srai shares bit 30
        3'b110:  arith_mode = ALU_OR;
        default: arith_mode = ALU_AND;
    endcase
end

always_comb begin
    rs_used_o     = '0;
    wr_rd         = 1'b0;
    alu_op1_sel_o = OP1_ZERO;
    alu_op2_sel_o = OP2_ZERO;
    alu_mode_o    = ALU_ADD;
    pc_mode_o     = PC_NEXT;
    ma_mode_o     = MA_NONE;
    ma_size_o     = MA_SIZE_W;
    wb_src_o      = WB_NONE;

    case (ins.r.opcode)
        OPC_LUI: begin
            wr_rd         = 1'b1;
            alu_op2_sel_o = OP2_IMM_U;
            alu_mode_o    = ALU_PASS_B;
            wb_src_o      = WB_ALU;
        end
        OPC_AUIPC: begin
            wr_rd         = 1'b1;
            alu_op1_sel_o = OP1_PC;
            alu_op2_sel_o = OP2_IMM_U;
            wb_src_o      = WB_ALU;
        end
        OPC_JAL, OPC_JALR: begin
            wr_rd         = 1'b1;
            rs_used_o[0]  = (ins.r.opcode == OPC_JALR);
            alu_op1_sel_o = OP1_PC;
            alu_op2_sel_o = OP2_FOUR;     // alu also forms the link
            pc_mode_o     = (ins.r.opcode == OPC_JALR) ? PC_JUMP_ABS : PC_JUMP_REL;
            wb_src_o      = WB_LINK;
        end
        OPC_BRANCH: begin
            rs_used_o = 2'b11;
            pc_mode_o = PC_BRANCH;
        end
        OPC_LOAD, OPC_STORE: begin
            rs_used_o[0]  = 1'b1;
            alu_op1_sel_o = OP1_RS1;
            ma_size_o     = ma_size_t'(ins.r.funct3);
            if (ins.r.opcode == OPC_LOAD) begin
                wr_rd         = 1'b1;
                alu_op2_sel_o = OP2_IMM_I;
                ma_mode_o     = MA_LOAD;
                wb_src_o      = WB_MEM;
            end else begin
                rs_used_o[1]  = 1'b1;   // store data
                alu_op2_sel_o = OP2_IMM_S;
                ma_mode_o     = MA_STORE;
            end
        end
        OPC_OP_IMM, OPC_OP: begin
            wr_rd         = 1'b1;
            rs_used_o[0]  = 1'b1;
            rs_used_o[1]  = (ins.r.opcode == OPC_OP);
            alu_op1_sel_o = OP1_RS1;
            alu_op2_sel_o = (ins.r.opcode == OPC_OP) ? OP2_RS2 : OP2_IMM_I;
            alu_mode_o    = arith_mode;
            wb_src_o      = WB_ALU;
        end
        default: ;  // unknown opcode, no side effects
    endcase

    wb_en_o = wr_rd && (ins.r.rd != '0);
end

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage
    import id_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  word_t              pc_i,
    input  word_t              instr_i,
    input  regaddr_t           rd_i,
    input  logic [2:0]         funct3_i,
    input  word_t              imm_i_i,
    input  word_t              imm_s_i,
    input  word_t              imm_b_i,
    input  word_t              imm_u_i,
    input  word_t              imm_j_i,
    input  alu_op1_t           alu_op1_sel_i,
    input  alu_op2_t           alu_op2_sel_i,
    input  alu_mode_t          alu_mode_i,
    input  pc_mode_t           pc_mode_i,
    input  ma_mode_t           ma_mode_i,
    input  ma_size_t           ma_size_i,
    input  wb_src_t            wb_src_i,
    input  logic               wb_en_i,
    input  word_t              op_value_i [NUM_SRC],
    input  logic [NUM_SRC-1:0] op_hazard_i,
    output logic               jmp_valid_o,
    output word_t              jmp_addr_o,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output word_t              pc_o,
    output word_t              instr_o,
    output word_t              alu_op1_o,
    output word_t              alu_op2_o,
    output alu_mode_t          alu_mode_o,
    output ma_mode_t           ma_mode_o,
    output ma_size_t           ma_size_o,
    output word_t              ma_data_o,
    output wb_src_t            wb_src_o,
    output regaddr_t           wb_addr_o,
    output logic               wb_en_o,
    output word_t              link_o
);

word_t rs1_val;
word_t rs2_val;
word_t op1;
word_t op2;
logic  hazard;
logic  take;       // instruction accepted this edge
logic  br_taken;

assign rs1_val    = op_value_i[0];
assign rs2_val    = op_value_i[1];
assign hazard     = |op_hazard_i;
assign in_ready_o = !hazard && (!out_valid_o || out_ready_i);
assign take       = in_valid_i && in_ready_o;

always_comb begin
    case (alu_op1_sel_i)
        OP1_RS1: op1 = rs1_val;
        OP1_PC:  op1 = pc_i;
        default: op1 = '0;
    endcase
    case (alu_op2_sel_i)
        OP2_RS2:   op2 = rs2_val;
        OP2_IMM_I: op2 = imm_i_i;
        OP2_IMM_S: op2 = imm_s_i;
        OP2_IMM_U: op2 = imm_u_i;
        OP2_FOUR:  op2 = word_t'(INSTR_BYTES);
        default:   op2 = '0;
    endcase
end

always_comb begin
    case (funct3_i)
        F3_BEQ:  br_taken = (rs1_val == rs2_val);
        F3_BNE:  br_taken = (rs1_val != rs2_val);
        F3_BLT:  br_taken = ($signed(rs1_val) < $signed(rs2_val));
        F3_BGE:  br_taken = ($signed(rs1_val) >= $signed(rs2_val));
        F3_BLTU: br_taken = (rs1_val < rs2_val);
        F3_BGEU: br_taken = (rs1_val >= rs2_val);
        default: br_taken = 1'b0;
    endcase
end

// jal does not depend on any register, so it never waits
always_comb begin
    jmp_valid_o = 1'b0;
    jmp_addr_o  = pc_i + imm_j_i;
    case (pc_mode_i)
        PC_JUMP_REL: jmp_valid_o = in_valid_i;
        PC_JUMP_ABS: begin
            jmp_valid_o = in_valid_i && !hazard;
            jmp_addr_o  = (rs1_val + imm_i_i) & ~word_t'(1);
        end
        PC_BRANCH: begin
            jmp_valid_o = in_valid_i && !hazard && br_taken;
            jmp_addr_o  = pc_i + imm_b_i;
        end
        default: ;
    endcase
end

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        out_valid_o <= 1'b0;
        wb_en_o     <= 1'b0;
        ma_mode_o   <= MA_NONE;
    end else if (take) begin
        out_valid_o <= 1'b1;
        wb_en_o     <= wb_en_i;
        ma_mode_o   <= ma_mode_i;
    end else if (out_ready_i) begin
        out_valid_o <= 1'b0;  // drained, bubble
    end
end

// payload only moves with an accepted instruction
always_ff @(posedge clk_i) begin
    if (take) begin
        pc_o       <= pc_i;
        instr_o    <= instr_i;
        alu_op1_o  <= op1;
        alu_op2_o  <= op2;
        alu_mode_o <= alu_mode_i;
        ma_size_o  <= ma_size_i;
        ma_data_o  <= rs2_val;
        wb_src_o   <= wb_src_i;
        wb_addr_o  <= rd_i;
        link_o     <= pc_i + word_t'(INSTR_BYTES);
    end
end

endmodule

/* logic/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
    import id_pkg::*;
(
    input  regaddr_t rs_idx_i,
    input  logic     rs_used_i,
    input  word_t    rf_data_i,
    input  logic     ex_valid_i,
    input  regaddr_t ex_addr_i,
    input  word_t    ex_data_i,
    input  logic     ex_ready_i,
    input  logic     ma_valid_i,
    input  regaddr_t ma_addr_i,
    input  word_t    ma_data_i,
    input  logic     ma_ready_i,
    input  logic     wb_valid_i,
    input  regaddr_t wb_addr_i,
    input  word_t    wb_data_i,
    output word_t    value_o,
    output logic     hazard_o
);

typedef enum logic [1:0] {SRC_REGFILE, SRC_EX, SRC_MA, SRC_WB} bypass_src_t;

bypass_src_t src;
logic        live;

assign live = (rs_idx_i != '0);  // x0 never forwards

// youngest producer wins
always_comb begin
    if (live && ex_valid_i && ex_addr_i == rs_idx_i) begin
        src = SRC_EX;
    end else if (live && ma_valid_i && ma_addr_i == rs_idx_i) begin
        src = SRC_MA;
    end else if (live && wb_valid_i && wb_addr_i == rs_idx_i) begin
        src = SRC_WB;
    end else begin
        src = SRC_REGFILE;
    end
end

always_comb begin
    case (src)
        SRC_EX:  value_o = ex_data_i;
        SRC_MA:  value_o = ma_data_i;
        SRC_WB:  value_o = wb_data_i;
        default: value_o = rf_data_i;
    endcase
end

// data not produced yet, e.g. a load still in flight
assign hazard_o = rs_used_i && ((src == SRC_EX && !ex_ready_i) ||
                                (src == SRC_MA && !ma_ready_i));

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import id_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  regaddr_t rd_addr_i [NUM_SRC],
    output word_t    rd_data_o [NUM_SRC],
    input  logic     wr_en_i,
    input  regaddr_t wr_addr_i,
    input  word_t    wr_data_i
);

word_t regs_r [NUM_REGS];

always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        for (int n = 0; n < NUM_REGS; n++) begin
            regs_r[n] <= '0;
        end
    end else if (wr_en_i && wr_addr_i != '0) begin
        regs_r[wr_addr_i] <= wr_data_i;   // x0 stays zero
    end
end

// same-cycle write is not visible here
always_comb begin
    for (int k = 0; k < NUM_SRC; k++) begin
        rd_data_o[k] = (rd_addr_i[k] == '0) ? '0 : regs_r[rd_addr_i[k]];
    end
end

endmodule

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_decode_stage -f vlog.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"

/* tests/decode_stim.txt */
// id kind(0 wb write, 1 issue, 2 issue after ex hazard, 3 back-pressure stream) pc instr
// fwd(b0 exv b1 exrdy b4 mav b5 mardy b8 wbv) addrs(ex ma wb) ex ma wb exp jmp op1 op2 mdata link
2 0 0 0 100 010000 0 0 123 0 0 0 0 0 0
2 0 0 0 100 020000 0 0 fffffff0 0 0 0 0 0 0
2 1 100 002081b3 0 0 0 0 0 12000 0 123 fffffff0 fffffff0 104
2 1 104 40208233 0 0 0 0 0 12010 0 123 fffffff0 fffffff0 108
2 1 108 ffb08293 0 0 0 0 0 12000 0 123 fffffffb 0 10c
2 1 10c 12345337 0 0 0 0 0 120a0 0 0 12345000 0 110
2 1 110 fe20ae23 0 0 0 0 0 2200 0 123 fffffffc fffffff0 114
2 1 114 00314383 0 0 0 0 0 14100 0 fffffff0 3 0 118
2 1 118 00108013 0 0 0 0 0 2000 0 123 1 123 11c
3 1 200 00048413 133 090909 eeee0001 aaaa0002 bbbb0003 12000 0 eeee0001 0 0 204
3 1 204 00048413 130 090909 eeee0011 aaaa0012 0 12000 0 aaaa0012 0 0 208
3 1 208 00048413 100 090909 0 0 bbbb0023 12000 0 bbbb0023 0 0 20c
3 1 20c 00048413 0 0 0 0 0 12000 0 bbbb0023 0 0 210
3 1 210 00000413 133 0 eeee0041 aaaa0042 bbbb0043 12000 0 0 0 0 214
4 2 300 002505b3 1 a 5a5a5a5a 0 0 12000 0 5a5a5a5a fffffff0 fffffff0 304
4 2 304 00150863 1 a 123 0 0 2001 314 0 0 123 308
5 1 1000 ff9ff0ef 0 0 0 0 0 12001 ff8 1000 4 0 1004
5 1 1010 00608267 0 0 0 0 0 12001 128 1010 4 0 1014
5 1 1020 00208863 0 0 0 0 0 2000 0 0 0 fffffff0 1024
5 1 1030 fe2098e3 0 0 0 0 0 2001 1020 0 0 fffffff0 1034
5 1 1040 0020c863 0 0 0 0 0 2000 0 0 0 fffffff0 1044
5 1 1050 0020d863 0 0 0 0 0 2001 1060 0 0 fffffff0 1054
5 1 1060 0020e863 0 0 0 0 0 2001 1070 0 0 fffffff0 1064
5 1 1070 0020f863 0 0 0 0 0 2000 0 0 0 fffffff0 1074
6 3 2000 002081b3 0 0 0 0 0 12000 0 123 fffffff0 fffffff0 2004
6 3 2004 ffb08293 0 0 0 0 0 12000 0 123 fffffffb 0 2008
6 3 2008 12345337 0 0 0 0 0 120a0 0 0 12345000 0 200c
6 3 200c fe20ae23 0 0 0 0 0 2200 0 123 fffffffc fffffff0 2010
6 3 2010 40208233 0 0 0 0 0 12010 0 123 fffffff0 fffffff0 2014
6 3 2014 00314383 0 0 0 0 0 14100 0 fffffff0 3 0 2018

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_alu_mode(input string name, input alu_mode_t got, input alu_mode_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %s, expected %s", $time, name,
                 got.name(), exp.name());
    end
endtask

task automatic check_ma(input string name, input ma_mode_t got, input ma_mode_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %s, expected %s", $time, name,
                 got.name(), exp.name());
    end
endtask

task automatic check_size(input string name, input ma_size_t got, input ma_size_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %s, expected %s", $time, name,
                 got.name(), exp.name());
    end
endtask

task automatic check_wb_src(input string name, input wb_src_t got, input wb_src_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %s, expected %s", $time, name,
                 got.name(), exp.name());
    end
endtask

task automatic check_reg(input string name, input regaddr_t got, input regaddr_t exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is x%0d, expected x%0d", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic report_error(input string what);
    n_errors++;
    $display("ERROR at %0d ns: %s", $time, what);
endtask

`endif

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import id_pkg::*;
();

localparam int ROW_WORDS  = 15;     // words per stimulus line
localparam int MAX_ROWS   = 64;
localparam int STIM_DEPTH = 1024;
localparam int TIMEOUT    = 100;

logic clk_i, arst_n_i, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
logic ex_wb_valid_i, ex_wb_ready_i, ma_wb_valid_i, ma_wb_ready_i, wb_valid_i;
regaddr_t  ex_wb_addr_i, ma_wb_addr_i, wb_addr_i, wb_addr_o;
word_t     pc_i, instr_i, ex_wb_data_i, ma_wb_data_i, wb_data_i, jmp_addr_o;
word_t     pc_o, instr_o, alu_op1_o, alu_op2_o, ma_data_o, link_o;
logic      jmp_valid_o, wb_en_o;
alu_mode_t alu_mode_o;
ma_mode_t  ma_mode_o;
ma_size_t  ma_size_o;
wb_src_t   wb_src_o;

word_t       stim [STIM_DEPTH];
logic [31:0] lfsr;
logic        aborted;
int          n_tests;
int          n_failed;

`include "tb_checks.svh"

decode_stage i_dut (.*);

initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
end

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
endfunction

function automatic word_t col(input int r, input int c);
    return stim[10'(r * ROW_WORDS + c)];
endfunction

// write-back source implied by the major opcode
function automatic wb_src_t wb_src_of(input word_t ins);
    wb_src_t src;
    case (ins[6:0])
        OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP: src = WB_ALU;
        OPC_LOAD:                               src = WB_MEM;
        OPC_JAL, OPC_JALR:                      src = WB_LINK;
        default:                                src = WB_NONE;
    endcase
    return src;
endfunction

task automatic idle_inputs();
    in_valid_i    = 1'b0;
    pc_i          = '0;
    instr_i       = '0;
    ex_wb_valid_i = 1'b0;
    ex_wb_ready_i = 1'b0;
    ex_wb_addr_i  = '0;
    ex_wb_data_i  = '0;
    ma_wb_valid_i = 1'b0;
    ma_wb_ready_i = 1'b0;
    ma_wb_addr_i  = '0;
    ma_wb_data_i  = '0;
    wb_valid_i    = 1'b0;
    wb_addr_i     = '0;
    wb_data_i     = '0;
endtask

task automatic drive_row(input int r);
    word_t fl;
    word_t ad;
    fl = col(r, 4);
    ad = col(r, 5);
    pc_i          = col(r, 2);
    instr_i       = col(r, 3);
    ex_wb_valid_i = fl[0];
    ex_wb_ready_i = fl[1];
    ma_wb_valid_i = fl[4];
    ma_wb_ready_i = fl[5];
    wb_valid_i    = fl[8];
    ex_wb_addr_i  = ad[4:0];
    ma_wb_addr_i  = ad[12:8];
    wb_addr_i     = ad[20:16];
    ex_wb_data_i  = col(r, 6);
    ma_wb_data_i  = col(r, 7);
    wb_data_i     = col(r, 8);
endtask

task automatic check_outputs(input int r);
    word_t ex;
    word_t ins;
    ex  = col(r, 9);
    ins = col(r, 3);
    check_bit("out_valid_o", out_valid_o, 1'b1);
    check_word("pc_o", pc_o, col(r, 2));
    check_word("instr_o", instr_o, ins);
    check_word("alu_op1_o", alu_op1_o, col(r, 11));
    check_word("alu_op2_o", alu_op2_o, col(r, 12));
    check_alu_mode("alu_mode_o", alu_mode_o, alu_mode_t'(ex[7:4]));
    check_ma("ma_mode_o", ma_mode_o, ma_mode_t'(ex[9:8]));
    check_size("ma_size_o", ma_size_o, ma_size_t'(ex[14:12]));
    check_word("ma_data_o", ma_data_o, col(r, 13));
    check_wb_src("wb_src_o", wb_src_o, wb_src_of(ins));
    check_reg("wb_addr_o", wb_addr_o, ins[11:7]);   // rd field
    check_bit("wb_en_o", wb_en_o, ex[16]);
    check_word("link_o", link_o, col(r, 14));
endtask

task automatic check_jump(input int r);
    word_t ex;
    ex = col(r, 9);
    check_bit("jmp_valid_o", jmp_valid_o, ex[0]);
    if (ex[0]) begin
        check_word("jmp_addr_o", jmp_addr_o, col(r, 10));
    end
endtask

// called at a falling edge, returns once in_ready_o is seen high
task automatic wait_in_ready(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT) begin
        if (in_ready_o) begin
            ok = 1'b1;
        end else begin
            @(negedge clk_i);
            n++;
        end
    end
    if (!ok) begin
        report_error("in_ready_o stayed low, instruction never accepted");
        aborted = 1'b1;
    end
endtask

task automatic run_write(input int r);
    drive_row(r);
    @(posedge clk_i);
    #2;
    idle_inputs();
endtask

task automatic run_issue(input int r);
    logic ok;
    drive_row(r);
    in_valid_i  = 1'b1;
    out_ready_i = 1'b1;
    if (col(r, 1) == 2) begin
        repeat (3) begin    // producer not ready yet
            @(negedge clk_i);
            check_bit("in_ready_o", in_ready_o, 1'b0);
            check_bit("jmp_valid_o", jmp_valid_o, 1'b0);
        end
        @(posedge clk_i);
        #2;
        ex_wb_ready_i = 1'b1;
    end
    @(negedge clk_i);
    wait_in_ready(ok);
    if (!ok) begin
        return;
    end
    check_jump(r);
    @(posedge clk_i);
    #2;
    idle_inputs();
    check_outputs(r);
    @(posedge clk_i);
    #2;
    check_bit("out_valid_o", out_valid_o, 1'b0);  // issued only once
endtask

task automatic run_stream(input int first, input int count);
    int    sent;
    int    got;
    int    cycles;
    logic  acc;
    logic  held;
    word_t held_pc;
    word_t held_op1;
    sent   = 0;
    got    = 0;
    cycles = 0;
    held   = 1'b0;
    while (got < count && cycles < TIMEOUT) begin
        if (sent < count) begin
            drive_row(first + sent);
            in_valid_i = 1'b1;
        end else begin
            idle_inputs();
        end
        lfsr        = lfsr_step(lfsr);
        out_ready_i = lfsr[0];
        @(negedge clk_i);
        if (held) begin
            check_bit("out_valid_o", out_valid_o, 1'b1);
            check_word("pc_o", pc_o, held_pc);
            check_word("alu_op1_o", alu_op1_o, held_op1);
        end
        acc      = in_valid_i && in_ready_o;
        held     = out_valid_o && !out_ready_i;
        held_pc  = pc_o;
        held_op1 = alu_op1_o;
        if (out_valid_o && out_ready_i) begin
            check_outputs(first + got);     // in issue order
            got++;
        end
        @(posedge clk_i);
        #2;
        if (acc) begin
            sent++;
        end
        cycles++;
    end
    idle_inputs();
    out_ready_i = 1'b1;
    if (got < count) begin
        report_error("stream under back-pressure did not drain");
        aborted = 1'b1;
    end else begin
        check_bit("out_valid_o", out_valid_o, 1'b0);   // nothing extra
    end
endtask

task automatic end_test(input word_t id, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
        $display("test %0d ok", id);
    end else begin
        n_failed++;
        $display("test %0d had %0d errors", id, n_errors - errs_before);
    end
endtask

initial begin
    word_t cur_id;
    int    r;
    int    first;
    int    cnt;
    int    errs_before;
    idle_inputs();
    instr_i     = 32'h0000006f;       // jal that must not fire
    arst_n_i    = 1'b0;
    out_ready_i = 1'b0;
    lfsr        = 32'h85dd;
    aborted     = 1'b0;
    n_tests     = 0;
    n_failed    = 0;
    stim        = '{default: '1};     // all ones marks the end
    $readmemh("tests/decode_stim.txt", stim);
    repeat (3) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    errs_before = n_errors;
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("wb_en_o", wb_en_o, 1'b0);
    check_bit("jmp_valid_o", jmp_valid_o, 1'b0);
    end_test(1, errs_before);
    idle_inputs();

    r = 0;
    while (r < MAX_ROWS && col(r, 0) != '1 && !aborted) begin
        cur_id      = col(r, 0);
        errs_before = n_errors;
        while (r < MAX_ROWS && col(r, 0) == cur_id && !aborted) begin
            if (col(r, 1) == 0) begin
                run_write(r);
                r++;
            end else if (col(r, 1) == 3) begin
                first = r;
                cnt   = 0;
                while (r < MAX_ROWS && col(r, 0) == cur_id && col(r, 1) == 3) begin
                    r++;
                    cnt++;
                end
                run_stream(first, cnt);
            end else begin
                run_issue(r);
                r++;
            end
        end
        end_test(cur_id, errs_before);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed,
             n_checks, n_errors);
    if (n_errors == 0 && !aborted) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

/* vlog.f */
+incdir+tests
logic/id_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/issue_stage.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv
